// ==== filelist.f ====
src/normCorrPkg.sv
src/frameStore.sv
src/convolver.sv
src/energyScaler.sv
src/lagCorrelator.sv
src/excfUpdater.sv
src/corrSequencer.sv
src/normCorr.sv
sim/normCorrTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the normCorr testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
	--top-module normCorrTb -f filelist.f -o normCorrSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/normCorrSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "TEST PASSED"; then
	exit 0
fi
exit 1

// ==== sim/normCorrTb.sv ====
module normCorrTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int SUBFR_LEN = 40;
	localparam int MAX_LAG = 143;
	localparam int EXC_LEN = MAX_LAG + SUBFR_LEN;
	localparam int EXC_AW = $clog2(EXC_LEN);
	localparam int LAG_W = $clog2(MAX_LAG + 1);
	localparam int CLK_PERIOD = 20;
	localparam int DRIVE_DELAY = 2;
	localparam int ENERGY_LIMIT = 67108864;
	localparam longint MAX32 = 64'sd2147483647;
	localparam longint MIN32 = -64'sd2147483648;
	localparam int CYCLES_PER_LAG = 100;	// One correlate plus one update phase
	localparam int ROW_OVERHEAD = 1500;	// Loads, convolution, energy pass

	// h shapes
	localparam int H_DECAY = 0;
	localparam int H_RAND = 1;
	localparam int H_FULL = 2;

	typedef struct packed {
		int tMin;
		int tMax;
		int ampMask;
		int hKind;
		int expScaled;	// 0 unscaled, 1 scaled, 2 either
		int expSat;
		int extraStart;
	} testRow;

	localparam int NUM_TESTS = 6;
	// tMin, tMax, sample mask, h shape, energy path, saturation, start while busy
	localparam testRow TEST_TABLE [NUM_TESTS] = '{
		'{20, 30, 32'h003f, H_DECAY, 0, 0, 0},
		'{40, 52, 32'h03ff, H_DECAY, 1, 0, 1},
		'{130, 143, 32'hffff, H_FULL, 1, 1, 0},
		'{77, 77, 32'h00ff, H_RAND, 0, 0, 1},
		'{20, 143, 32'h01ff, H_RAND, 2, 0, 0},
		'{100, 110, 32'h7fff, H_DECAY, 2, 0, 0}
	};

	logic clk;
	logic reset;
	logic loadEn;
	logic [1:0] loadSel;
	logic [EXC_AW-1:0] loadAddr;
	logic signed [15:0] loadData;
	logic start;
	logic [LAG_W-1:0] tMin;
	logic [LAG_W-1:0] tMax;
	logic busy;
	logic done;
	logic resultValid;
	logic [LAG_W-1:0] resultLag;
	logic signed [31:0] resultEnergy;
	logic signed [31:0] resultCorr;

	int seed = 20;
	int errorCount = 0;
	int checkCount = 0;
	int excModel [EXC_LEN];
	int hModel [SUBFR_LEN];
	int xnModel [SUBFR_LEN];
	int expEnergy [$];
	int expCorr [$];
	bit modelScaled;
	bit modelSat;

	normCorr #(.SUBFR_LEN(SUBFR_LEN), .MAX_LAG(MAX_LAG)) i_normCorr (
		.clk(clk), .reset(reset), .loadEn(loadEn), .loadSel(loadSel),
		.loadAddr(loadAddr), .loadData(loadData), .start(start), .tMin(tMin),
		.tMax(tMax), .busy(busy), .done(done), .resultValid(resultValid),
		.resultLag(resultLag), .resultEnergy(resultEnergy), .resultCorr(resultCorr)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//////////////////////////////
	// Reference arithmetic

	function automatic int clampLong(input longint v);
		if (v > MAX32)
			return int'(MAX32);
		if (v < MIN32)
			return int'(MIN32);
		return int'(v);
	endfunction

	function automatic int addSample(input int a, input int b);
		int s;
		s = a + b;
		if (s > 32767)
			return 32767;
		if (s < -32768)
			return -32768;
		return s;
	endfunction

	function automatic int multiplyQ15(input int a, input int b);
		if (a == -32768 && b == -32768)
			return int'(MAX32);	// Only product that overflows
		return a * b * 2;
	endfunction

	function automatic int accumulateProduct(input int acc, input int a, input int b);
		return clampLong(longint'(acc) + longint'(multiplyQ15(a, b)));
	endfunction

	function automatic int shiftLeftSat(input int x, input int n);
		return clampLong(longint'(x) * longint'(1 << n));
	endfunction

	function automatic int highHalf(input int x);
		return x >>> 16;
	endfunction

	// Random value inside mask, sign taken from the mask's top bit
	function automatic int randomSample(input int mask);
		int v;
		v = $random(seed) & mask;
		if ((v & ~(mask >>> 1)) != 0)
			v = v | ~mask;
		return v;
	endfunction

	//////////////////////////////
	// Checks and bus helpers

	task automatic checkValue(input string name, input int expected, input int actual);
		checkCount++;
		assert (actual == expected)
		else
		begin
			$display("CHECK FAILED time=%0d ns %s expected=%0d actual=%0d",
				$time, name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic checkCondition(input bit ok, input string what);
		checkCount++;
		assert (ok)
		else
		begin
			$display("Error at %0d ns: %s", $time, what);
			errorCount++;
		end
	endtask

	task automatic nextCycle();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic checkQuiet();
		checkValue("busy", 0, int'(busy));
		checkValue("done", 0, int'(done));
		checkValue("resultValid", 0, int'(resultValid));
	endtask

	task automatic loadWord(input int sel, input int addr, input int data);
		loadEn = 1'b1;
		loadSel = 2'(sel);
		loadAddr = EXC_AW'(addr);
		loadData = 16'(data);
		nextCycle();
		checkQuiet();	// Nothing may move between frames
	endtask

	task automatic generateStimulus(input int mask, input int hKind);
		for (int a = 0; a < EXC_LEN; a++)
			excModel[a] = randomSample(mask);
		for (int n = 0; n < SUBFR_LEN; n++)
		begin
			case (hKind)
				H_DECAY: hModel[n] = 16384 >>> (n >> 2);
				H_RAND: hModel[n] = randomSample(32'h0fff);
				default: hModel[n] = randomSample(32'hffff);
			endcase
		end
		for (int n = 0; n < SUBFR_LEN; n++)
			xnModel[n] = randomSample(mask);
	endtask

	task automatic loadFrame();
		for (int a = 0; a < EXC_LEN; a++)
			loadWord(0, a, excModel[a]);
		for (int n = 0; n < SUBFR_LEN; n++)
			loadWord(1, n, hModel[n]);
		for (int n = 0; n < SUBFR_LEN; n++)
			loadWord(2, n, xnModel[n]);
		loadEn = 1'b0;
	endtask

	//////////////////////////////
	// Expected energy and correlation per lag

	task automatic computeExpected(input int lagLo, input int lagHi);
		int excf [SUBFR_LEN];
		int acc;
		int energy;
		int corr;
		int hFac;
		int scaling;
		int k;
		expEnergy.delete();
		expCorr.delete();
		modelSat = 1'b0;
		k = MAX_LAG - lagLo;	// Memory index of exc[-lagLo]
		for (int n = 0; n < SUBFR_LEN; n++)
		begin
			acc = 0;
			for (int i = 0; i <= n; i++)
				acc = accumulateProduct(acc, excModel[k + i], hModel[n - i]);
			excf[n] = highHalf(shiftLeftSat(acc, 3));
		end
		energy = 0;
		for (int j = 0; j < SUBFR_LEN; j++)
			energy = accumulateProduct(energy, excf[j], excf[j]);
		modelScaled = energy > ENERGY_LIMIT;
		hFac = modelScaled ? 1 : 3;
		scaling = modelScaled ? 2 : 0;
		if (modelScaled)
		begin
			for (int j = 0; j < SUBFR_LEN; j++)
				excf[j] = excf[j] >>> 2;
		end
		for (int lag = lagLo; lag <= lagHi; lag++)
		begin
			energy = 0;
			corr = 0;
			for (int j = 0; j < SUBFR_LEN; j++)
			begin
				energy = accumulateProduct(energy, excf[j], excf[j]);
				corr = accumulateProduct(corr, xnModel[j], excf[j]);
			end
			expEnergy.push_back(energy);
			expCorr.push_back(corr);
			if (energy == int'(MAX32))
				modelSat = 1'b1;
			if (lag < lagHi)
			begin
				k = MAX_LAG - (lag + 1);	// Next older sample
				for (int j = SUBFR_LEN - 1; j >= 1; j--)
					excf[j] = addSample(highHalf(shiftLeftSat(
						multiplyQ15(excModel[k], hModel[j]), hFac)), excf[j - 1]);
				excf[0] = excModel[k] >>> scaling;
			end
		end
	endtask

	//////////////////////////////
	// One table row

	task automatic runRow(input int r);
		testRow row;
		int errorsBefore;
		int nLags;
		int resultCount;
		int cycle;
		bit doneSeen;
		bit prevBusy;
		row = TEST_TABLE[r];
		errorsBefore = errorCount;
		generateStimulus(row.ampMask, row.hKind);
		loadFrame();
		computeExpected(row.tMin, row.tMax);
		if (row.expScaled != 2)
			checkCondition(int'(modelScaled) == row.expScaled,
				"stimulus missed the intended energy path");
		if (row.expSat != 0)
			checkCondition(modelSat, "stimulus did not saturate the energy sum");
		nLags = row.tMax - row.tMin + 1;
		tMin = LAG_W'(row.tMin);
		tMax = LAG_W'(row.tMax);
		start = 1'b1;
		nextCycle();
		start = 1'b0;
		checkValue("busy", 1, int'(busy));
		resultCount = 0;
		doneSeen = 1'b0;
		prevBusy = 1'b1;
		cycle = 0;
		while (!doneSeen)
		begin
			start = (row.extraStart != 0 && cycle == 50);	// Must be ignored
			nextCycle();
			cycle++;
			if (resultValid)
			begin
				checkCondition(resultCount < nLags, "result arrived after the last lag");
				if (resultCount < nLags)
				begin
					checkValue("resultLag", row.tMin + resultCount, int'(resultLag));
					checkValue("resultEnergy", expEnergy[resultCount], resultEnergy);
					checkValue("resultCorr", expCorr[resultCount], resultCorr);
				end
				resultCount++;
			end
			if (done)
			begin
				doneSeen = 1'b1;
				checkValue("busy at done", 0, int'(busy));
				checkValue("busy before done", 1, int'(prevBusy));
			end
			prevBusy = busy;
		end
		start = 1'b0;
		checkValue("result count", nLags, resultCount);
		repeat (5)
		begin
			nextCycle();
			checkQuiet();	// No second frame from the extra start
		end
		$display("Test %0d: lags %0d to %0d, %0d results, %0s path, %0d errors",
			r, row.tMin, row.tMax, resultCount, modelScaled ? "scaled" : "unscaled",
			errorCount - errorsBefore);
	endtask

	initial
	begin
		reset = 1'b1;
		loadEn = 1'b0;
		loadSel = '0;
		loadAddr = '0;
		loadData = '0;
		start = 1'b0;
		tMin = '0;
		tMax = '0;
		repeat (2) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;
		repeat (4)
		begin
			nextCycle();
			checkQuiet();
		end
		$display("Reset test: outputs idle, %0d errors", errorCount);
		for (int r = 0; r < NUM_TESTS; r++)
			runRow(r);
		$display("Summary: %0d tests, %0d checks, %0d errors",
			NUM_TESTS + 1, checkCount, errorCount);
		if (errorCount == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Watchdog scaled to the lag count of the whole table
	initial
	begin
		longint limitCycles;
		limitCycles = 20;
		for (int r = 0; r < NUM_TESTS; r++)
			limitCycles += ROW_OVERHEAD
				+ (TEST_TABLE[r].tMax - TEST_TABLE[r].tMin + 1) * CYCLES_PER_LAG;
		limitCycles = limitCycles * 2;
		#(limitCycles * CLK_PERIOD);
		$display("Timeout: simulation still running after %0d cycles", limitCycles);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== src/normCorr.sv ====
module normCorr import normCorrPkg::*; #(
	parameter int SUBFR_LEN = 40,
	parameter int MAX_LAG = 143,
	localparam int EXC_AW = $clog2(MAX_LAG + SUBFR_LEN),
	localparam int SUB_AW = $clog2(SUBFR_LEN),
	localparam int LAG_W = $clog2(MAX_LAG + 1)
) (
	input logic clk,
	input logic reset,
	input logic loadEn,
	input logic [1:0] loadSel,
	input logic [EXC_AW-1:0] loadAddr,
	input logic signed [SAMPLE_W-1:0] loadData,
	input logic start,
	input logic [LAG_W-1:0] tMin,
	input logic [LAG_W-1:0] tMax,
	output logic busy,
	output logic done,
	output logic resultValid,
	output logic [LAG_W-1:0] resultLag,
	output logic signed [ACC_W-1:0] resultEnergy,
	output logic signed [ACC_W-1:0] resultCorr
);

	phaseT phase;
	logic convStart, convDone, energyStart, energyDone;
	logic corrStart, corrDone, updStart, updDone;
	logic [LAG_W-1:0] lag;
	logic [EXC_AW-1:0] excIdx, convExcAddr, updExcAddr;
	logic [SHIFT_W-1:0] hFac, scaling;
	logic signed [SAMPLE_W-1:0] excData, hData, excfData, xnData;
	logic [SUB_AW-1:0] convHAddr, updHAddr, energyExcfAddr, corrExcfAddr, updExcfAddr;
	logic [SUB_AW-1:0] corrXnAddr;

	// excf write ports, one per writing stage
	logic convWrEn, energyWrEn, updWrEn;
	logic [SUB_AW-1:0] convWrAddr, energyWrAddr, updWrAddr;
	logic signed [SAMPLE_W-1:0] convWrData, energyWrData, updWrData;

	corrSequencer #(.SUBFR_LEN(SUBFR_LEN), .MAX_LAG(MAX_LAG)) i_corrSequencer (
		.clk(clk), .reset(reset), .start(start), .tMin(tMin), .tMax(tMax),
		.convDone(convDone), .energyDone(energyDone), .corrDone(corrDone),
		.updDone(updDone), .phase(phase), .convStart(convStart),
		.energyStart(energyStart), .corrStart(corrStart), .updStart(updStart),
		.lag(lag), .excIdx(excIdx), .busy(busy), .done(done)
	);

	frameStore #(.SUBFR_LEN(SUBFR_LEN), .MAX_LAG(MAX_LAG)) i_frameStore (
		.clk(clk), .phase(phase), .loadEn(loadEn), .loadSel(loadSel),
		.loadAddr(loadAddr), .loadData(loadData),
		.convExcAddr(convExcAddr), .convHAddr(convHAddr),
		.updExcAddr(updExcAddr), .updHAddr(updHAddr),
		.energyExcfAddr(energyExcfAddr), .corrExcfAddr(corrExcfAddr),
		.updExcfAddr(updExcfAddr), .corrXnAddr(corrXnAddr),
		.excData(excData), .hData(hData), .excfData(excfData), .xnData(xnData),
		.convWrEn(convWrEn), .convWrAddr(convWrAddr), .convWrData(convWrData),
		.energyWrEn(energyWrEn), .energyWrAddr(energyWrAddr), .energyWrData(energyWrData),
		.updWrEn(updWrEn), .updWrAddr(updWrAddr), .updWrData(updWrData)
	);

	convolver #(.SUBFR_LEN(SUBFR_LEN), .MAX_LAG(MAX_LAG)) i_convolver (
		.clk(clk), .reset(reset), .convStart(convStart), .excIdx(excIdx),
		.excAddr(convExcAddr), .hAddr(convHAddr), .excfWrEn(convWrEn),
		.excfWrAddr(convWrAddr), .excfWrData(convWrData),
		.excData(excData), .hData(hData), .convDone(convDone)
	);

	energyScaler #(.SUBFR_LEN(SUBFR_LEN)) i_energyScaler (
		.clk(clk), .reset(reset), .energyStart(energyStart), .excfData(excfData),
		.excfRdAddr(energyExcfAddr), .excfWrEn(energyWrEn), .excfWrAddr(energyWrAddr),
		.excfWrData(energyWrData), .hFac(hFac), .scaling(scaling),
		.energyDone(energyDone)
	);

	lagCorrelator #(.SUBFR_LEN(SUBFR_LEN), .MAX_LAG(MAX_LAG)) i_lagCorrelator (
		.clk(clk), .reset(reset), .corrStart(corrStart), .lag(lag),
		.excfData(excfData), .xnData(xnData), .excfRdAddr(corrExcfAddr),
		.xnRdAddr(corrXnAddr), .resultValid(resultValid), .resultLag(resultLag),
		.resultEnergy(resultEnergy), .resultCorr(resultCorr), .corrDone(corrDone)
	);

	excfUpdater #(.SUBFR_LEN(SUBFR_LEN), .MAX_LAG(MAX_LAG)) i_excfUpdater (
		.clk(clk), .reset(reset), .updStart(updStart), .excIdx(excIdx),
		.hFac(hFac), .scaling(scaling), .excData(excData), .hData(hData),
		.excfData(excfData), .excAddr(updExcAddr), .hAddr(updHAddr),
		.excfRdAddr(updExcfAddr), .excfWrEn(updWrEn), .excfWrAddr(updWrAddr),
		.excfWrData(updWrData), .updDone(updDone)
	);

endmodule

// ==== src/corrSequencer.sv ====
module corrSequencer import normCorrPkg::*; #(
	parameter int SUBFR_LEN = 40,
	parameter int MAX_LAG = 143,
	localparam int EXC_AW = $clog2(MAX_LAG + SUBFR_LEN),
	localparam int LAG_W = $clog2(MAX_LAG + 1)
) (
	input logic clk,
	input logic reset,
	input logic start,
	input logic [LAG_W-1:0] tMin,
	input logic [LAG_W-1:0] tMax,
	input logic convDone,
	input logic energyDone,
	input logic corrDone,
	input logic updDone,
	output phaseT phase,
	output logic convStart,
	output logic energyStart,
	output logic corrStart,
	output logic updStart,
	output logic [LAG_W-1:0] lag,
	output logic [EXC_AW-1:0] excIdx,
	output logic busy,
	output logic done
);

	assign excIdx = EXC_AW'(MAX_LAG - lag);	// Address of exc[-lag]

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			phase <= PH_IDLE;
			convStart <= 1'b0;
			energyStart <= 1'b0;
			corrStart <= 1'b0;
			updStart <= 1'b0;
			lag <= '0;
			busy <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			convStart <= 1'b0;
			energyStart <= 1'b0;
			corrStart <= 1'b0;
			updStart <= 1'b0;
			done <= 1'b0;
			case (phase)
				PH_IDLE:
				begin
					if (start)
					begin
						busy <= 1'b1;
						lag <= tMin;
						phase <= PH_CONVOLVE;
						convStart <= 1'b1;
					end
				end
				PH_CONVOLVE:
				begin
					if (convDone)
					begin
						phase <= PH_ENERGY;
						energyStart <= 1'b1;
					end
				end
				PH_ENERGY:
				begin
					if (energyDone)
					begin
						phase <= PH_CORRELATE;
						corrStart <= 1'b1;
					end
				end
				PH_CORRELATE:
				begin
					if (corrDone && lag == tMax)	// No update after the last lag
					begin
						phase <= PH_IDLE;
						busy <= 1'b0;
						done <= 1'b1;
					end
					else if (corrDone)
					begin
						lag <= lag + 1'b1;
						phase <= PH_UPDATE;
						updStart <= 1'b1;
					end
				end
				PH_UPDATE:
				begin
					if (updDone)
					begin
						phase <= PH_CORRELATE;
						corrStart <= 1'b1;
					end
				end
				default: phase <= PH_IDLE;
			endcase
		end
	end

endmodule

// ==== src/excfUpdater.sv ====
module excfUpdater import normCorrPkg::*; #(
	parameter int SUBFR_LEN = 40,
	parameter int MAX_LAG = 143,
	localparam int EXC_AW = $clog2(MAX_LAG + SUBFR_LEN),
	localparam int SUB_AW = $clog2(SUBFR_LEN)
) (
	input logic clk,
	input logic reset,
	input logic updStart,
	input logic [EXC_AW-1:0] excIdx,
	input logic [SHIFT_W-1:0] hFac,
	input logic [SHIFT_W-1:0] scaling,
	input logic signed [SAMPLE_W-1:0] excData,
	input logic signed [SAMPLE_W-1:0] hData,
	input logic signed [SAMPLE_W-1:0] excfData,
	output logic [EXC_AW-1:0] excAddr,
	output logic [SUB_AW-1:0] hAddr,
	output logic [SUB_AW-1:0] excfRdAddr,
	output logic excfWrEn,
	output logic [SUB_AW-1:0] excfWrAddr,
	output logic signed [SAMPLE_W-1:0] excfWrData,
	output logic updDone
);

	localparam logic [SUB_AW-1:0] LAST = SUB_AW'(SUBFR_LEN - 1);

	logic issue, vld, lastD, tail;
	logic [SUB_AW-1:0] j, jD;
	accWord prod;

	assign excAddr = excIdx;	// Same new sample for every j
	assign hAddr = j;
	assign excfRdAddr = j - 1'b1;
	assign prod.whole = lShlSat(lMult(excData, hData), hFac);

	//////////////////////////////
	// Descending j so excf[j-1] is read before it is overwritten

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			issue <= 1'b0;
			vld <= 1'b0;
			tail <= 1'b0;
			j <= LAST;
			excfWrEn <= 1'b0;
			updDone <= 1'b0;
		end
		else
		begin
			vld <= issue;
			tail <= vld && lastD;	// Extra slot for excf[0]
			excfWrEn <= vld || tail;
			updDone <= tail;
			if (updStart)
			begin
				issue <= 1'b1;
				j <= LAST;
			end
			else if (issue)
			begin
				if (j == SUB_AW'(1))
					issue <= 1'b0;
				else
					j <= j - 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		lastD <= (j == SUB_AW'(1));
		jD <= j;
		if (tail)
		begin
			excfWrAddr <= '0;
			excfWrData <= shrArith(excData, scaling);
		end
		else
		begin
			excfWrAddr <= jD;
			excfWrData <= addSat(extractH(prod), excfData);
		end
	end

endmodule

// ==== src/lagCorrelator.sv ====
module lagCorrelator import normCorrPkg::*; #(
	parameter int SUBFR_LEN = 40,
	parameter int MAX_LAG = 143,
	localparam int SUB_AW = $clog2(SUBFR_LEN),
	localparam int LAG_W = $clog2(MAX_LAG + 1)
) (
	input logic clk,
	input logic reset,
	input logic corrStart,
	input logic [LAG_W-1:0] lag,
	input logic signed [SAMPLE_W-1:0] excfData,
	input logic signed [SAMPLE_W-1:0] xnData,
	output logic [SUB_AW-1:0] excfRdAddr,
	output logic [SUB_AW-1:0] xnRdAddr,
	output logic resultValid,
	output logic [LAG_W-1:0] resultLag,
	output logic signed [ACC_W-1:0] resultEnergy,
	output logic signed [ACC_W-1:0] resultCorr,
	output logic corrDone
);

	localparam logic [SUB_AW-1:0] LAST = SUB_AW'(SUBFR_LEN - 1);

	logic issue, vld, firstD, lastD;
	logic [SUB_AW-1:0] idx;
	logic signed [ACC_W-1:0] energyNext, corrNext;

	// Both memories share one index
	assign excfRdAddr = idx;
	assign xnRdAddr = idx;

	// Result registers double as the running sums
	assign energyNext = lMac(firstD ? '0 : resultEnergy, excfData, excfData);
	assign corrNext = lMac(firstD ? '0 : resultCorr, xnData, excfData);
	assign corrDone = resultValid;	// Phase ends with the strobe

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			issue <= 1'b0;
			vld <= 1'b0;
			idx <= '0;
			resultValid <= 1'b0;
		end
		else
		begin
			vld <= issue;
			resultValid <= vld && lastD;
			if (corrStart)
			begin
				issue <= 1'b1;
				idx <= '0;
			end
			else if (issue)
			begin
				if (idx == LAST)
					issue <= 1'b0;
				else
					idx <= idx + 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		firstD <= (idx == '0);
		lastD <= (idx == LAST);
		if (vld)
		begin
			resultEnergy <= energyNext;
			resultCorr <= corrNext;
		end
		if (corrStart)
			resultLag <= lag;
	end

endmodule

// ==== src/energyScaler.sv ====
module energyScaler import normCorrPkg::*; #(
	parameter int SUBFR_LEN = 40,
	localparam int SUB_AW = $clog2(SUBFR_LEN)
) (
	input logic clk,
	input logic reset,
	input logic energyStart,
	input logic signed [SAMPLE_W-1:0] excfData,
	output logic [SUB_AW-1:0] excfRdAddr,
	output logic excfWrEn,
	output logic [SUB_AW-1:0] excfWrAddr,
	output logic signed [SAMPLE_W-1:0] excfWrData,
	output logic [SHIFT_W-1:0] hFac,
	output logic [SHIFT_W-1:0] scaling,
	output logic energyDone
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_SUM = 2'd1;
	localparam logic [1:0] ST_SCALE = 2'd2;
	localparam logic [SUB_AW-1:0] LAST = SUB_AW'(SUBFR_LEN - 1);

	logic [1:0] state;
	logic issue, vld, lastD;
	logic [SUB_AW-1:0] idx, idxD;
	logic signed [ACC_W-1:0] energy, energyNext;

	assign excfRdAddr = idx;
	assign energyNext = lMac(idxD == '0 ? '0 : energy, excfData, excfData);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= ST_IDLE;
			issue <= 1'b0;
			vld <= 1'b0;
			idx <= '0;
			excfWrEn <= 1'b0;
			energyDone <= 1'b0;
			hFac <= HFAC_UNSCALED;
			scaling <= '0;
		end
		else
		begin
			vld <= issue;
			excfWrEn <= vld && state == ST_SCALE;
			energyDone <= 1'b0;
			if (issue)
			begin
				if (idx == LAST)
					issue <= 1'b0;
				else
					idx <= idx + 1'b1;
			end
			if (energyStart)
			begin
				state <= ST_SUM;
				issue <= 1'b1;
				idx <= '0;
			end
			if (vld && lastD)
			begin
				if (state == ST_SUM && energyNext > ENERGY_LIMIT)
				begin
					state <= ST_SCALE;	// Second pass rewrites excf in place
					issue <= 1'b1;
					idx <= '0;
					hFac <= HFAC_SCALED;
					scaling <= SCALE_SHIFT;
				end
				else
				begin
					if (state == ST_SUM)
					begin
						hFac <= HFAC_UNSCALED;
						scaling <= '0;
					end
					state <= ST_IDLE;
					energyDone <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		lastD <= (idx == LAST);
		idxD <= idx;
		if (vld && state == ST_SUM)
			energy <= energyNext;
		excfWrAddr <= idxD;
		excfWrData <= shrArith(excfData, SCALE_SHIFT);
	end

endmodule

// ==== src/convolver.sv ====
module convolver import normCorrPkg::*; #(
	parameter int SUBFR_LEN = 40,
	parameter int MAX_LAG = 143,
	localparam int EXC_AW = $clog2(MAX_LAG + SUBFR_LEN),
	localparam int SUB_AW = $clog2(SUBFR_LEN)
) (
	input logic clk,
	input logic reset,
	input logic convStart,
	input logic [EXC_AW-1:0] excIdx,
	output logic [EXC_AW-1:0] excAddr,
	output logic [SUB_AW-1:0] hAddr,
	output logic excfWrEn,
	output logic [SUB_AW-1:0] excfWrAddr,
	output logic signed [SAMPLE_W-1:0] excfWrData,
	input logic signed [SAMPLE_W-1:0] excData,
	input logic signed [SAMPLE_W-1:0] hData,
	output logic convDone
);

	localparam logic [SUB_AW-1:0] LAST = SUB_AW'(SUBFR_LEN - 1);

	logic running, vld, firstD, lastD;
	logic [SUB_AW-1:0] n, i, nD;
	accWord acc, accNext, shifted;

	assign excAddr = excIdx + EXC_AW'(i);
	assign hAddr = n - i;
	assign accNext.whole = lMac(firstD ? '0 : acc.whole, excData, hData);
	assign shifted.whole = lShlSat(accNext.whole, CONV_SHIFT);

	// Triangular loop, i runs 0..n for each output n
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			running <= 1'b0;
			vld <= 1'b0;
			n <= '0;
			i <= '0;
			excfWrEn <= 1'b0;
			convDone <= 1'b0;
		end
		else
		begin
			vld <= running;	// Data returns one cycle after the address
			excfWrEn <= vld && lastD;
			convDone <= vld && lastD && nD == LAST;
			if (convStart)
			begin
				running <= 1'b1;
				n <= '0;
				i <= '0;
			end
			else if (running)
			begin
				if (i == n)
				begin
					i <= '0;
					n <= n + 1'b1;
					if (n == LAST)
						running <= 1'b0;
				end
				else
					i <= i + 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		firstD <= (i == '0);
		lastD <= (i == n);
		nD <= n;
		if (vld)
			acc <= accNext;
		excfWrAddr <= nD;
		excfWrData <= extractH(shifted);
	end

endmodule

// ==== src/frameStore.sv ====
module frameStore import normCorrPkg::*; #(
	parameter int SUBFR_LEN = 40,
	parameter int MAX_LAG = 143,
	localparam int EXC_AW = $clog2(MAX_LAG + SUBFR_LEN),
	localparam int SUB_AW = $clog2(SUBFR_LEN)
) (
	input logic clk,
	input phaseT phase,
	input logic loadEn,
	input logic [1:0] loadSel,
	input logic [EXC_AW-1:0] loadAddr,
	input logic signed [SAMPLE_W-1:0] loadData,
	input logic [EXC_AW-1:0] convExcAddr,
	input logic [SUB_AW-1:0] convHAddr,
	input logic [EXC_AW-1:0] updExcAddr,
	input logic [SUB_AW-1:0] updHAddr,
	input logic [SUB_AW-1:0] energyExcfAddr,
	input logic [SUB_AW-1:0] corrExcfAddr,
	input logic [SUB_AW-1:0] updExcfAddr,
	input logic [SUB_AW-1:0] corrXnAddr,
	output logic signed [SAMPLE_W-1:0] excData,
	output logic signed [SAMPLE_W-1:0] hData,
	output logic signed [SAMPLE_W-1:0] excfData,
	output logic signed [SAMPLE_W-1:0] xnData,
	input logic convWrEn,
	input logic [SUB_AW-1:0] convWrAddr,
	input logic signed [SAMPLE_W-1:0] convWrData,
	input logic energyWrEn,
	input logic [SUB_AW-1:0] energyWrAddr,
	input logic signed [SAMPLE_W-1:0] energyWrData,
	input logic updWrEn,
	input logic [SUB_AW-1:0] updWrAddr,
	input logic signed [SAMPLE_W-1:0] updWrData
);

	logic signed [SAMPLE_W-1:0] excMem [MAX_LAG+SUBFR_LEN];	// Address a holds exc[a-MAX_LAG]
	logic signed [SAMPLE_W-1:0] hMem [SUBFR_LEN];
	logic signed [SAMPLE_W-1:0] xnMem [SUBFR_LEN];
	logic signed [SAMPLE_W-1:0] excfMem [SUBFR_LEN];

	logic [EXC_AW-1:0] excRdAddr;
	logic [SUB_AW-1:0] hRdAddr, excfRdAddr, excfWrAddr;
	logic excfWrEn;
	logic signed [SAMPLE_W-1:0] excfWrData;

	// Port routing by phase
	always_comb
	begin
		excRdAddr = convExcAddr;
		hRdAddr = convHAddr;
		excfRdAddr = corrExcfAddr;
		excfWrEn = 1'b0;
		excfWrAddr = convWrAddr;
		excfWrData = convWrData;
		case (phase)
			PH_CONVOLVE: excfWrEn = convWrEn;
			PH_ENERGY:
			begin
				excfRdAddr = energyExcfAddr;
				excfWrEn = energyWrEn;
				excfWrAddr = energyWrAddr;
				excfWrData = energyWrData;
			end
			PH_UPDATE:
			begin
				excRdAddr = updExcAddr;
				hRdAddr = updHAddr;
				excfRdAddr = updExcfAddr;
				excfWrEn = updWrEn;
				excfWrAddr = updWrAddr;
				excfWrData = updWrData;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (loadEn && phase == PH_IDLE)	// Host owns the memories only between frames
		begin
			case (loadSel)
				LOAD_EXC: excMem[loadAddr] <= loadData;
				LOAD_H: hMem[loadAddr[SUB_AW-1:0]] <= loadData;
				LOAD_XN: xnMem[loadAddr[SUB_AW-1:0]] <= loadData;
				default: ;
			endcase
		end
		if (excfWrEn)
			excfMem[excfWrAddr] <= excfWrData;
		excData <= excMem[excRdAddr];
		hData <= hMem[hRdAddr];
		excfData <= excfMem[excfRdAddr];
		xnData <= xnMem[corrXnAddr];
	end

endmodule

// ==== src/normCorrPkg.sv ====
package normCorrPkg;

	localparam int SAMPLE_W = 16;
	localparam int ACC_W = 32;
	localparam int SHIFT_W = 4;	// Wide enough for every shift count used here

	localparam logic signed [ACC_W-1:0] ACC_MAX = 32'sh7fffffff;
	localparam logic signed [ACC_W-1:0] ACC_MIN = 32'sh80000000;
	localparam logic signed [ACC_W-1:0] ENERGY_LIMIT = 32'sd67108864;	// 2^26

	localparam logic [SHIFT_W-1:0] CONV_SHIFT = 4'd3;
	localparam logic [SHIFT_W-1:0] HFAC_UNSCALED = 4'd3;
	localparam logic [SHIFT_W-1:0] HFAC_SCALED = 4'd1;
	localparam logic [SHIFT_W-1:0] SCALE_SHIFT = 4'd2;

	// Host load targets
	localparam logic [1:0] LOAD_EXC = 2'd0;
	localparam logic [1:0] LOAD_H = 2'd1;
	localparam logic [1:0] LOAD_XN = 2'd2;

	typedef union packed {
		logic signed [ACC_W-1:0] whole;
		struct packed {
			logic [SAMPLE_W-1:0] hi;
			logic [SAMPLE_W-1:0] lo;
		} half;
	} accWord;

	typedef enum logic [2:0] {
		PH_IDLE,
		PH_CONVOLVE,
		PH_ENERGY,
		PH_CORRELATE,
		PH_UPDATE
	} phaseT;

	//////////////////////////////
	// Basic operators

	function automatic logic signed [SAMPLE_W-1:0] addSat(
		input logic signed [SAMPLE_W-1:0] a,
		input logic signed [SAMPLE_W-1:0] b
	);
		logic signed [SAMPLE_W:0] sum;
		sum = a + b;
		if (sum[SAMPLE_W] != sum[SAMPLE_W-1])
			return sum[SAMPLE_W] ? {1'b1, {(SAMPLE_W-1){1'b0}}} : {1'b0, {(SAMPLE_W-1){1'b1}}};
		return sum[SAMPLE_W-1:0];
	endfunction

	function automatic logic signed [ACC_W-1:0] lMult(
		input logic signed [SAMPLE_W-1:0] a,
		input logic signed [SAMPLE_W-1:0] b
	);
		logic signed [ACC_W-1:0] prod;
		prod = a * b;
		if (prod == 32'sh40000000)	// Only -32768 * -32768 lands here
			return ACC_MAX;
		return prod <<< 1;
	endfunction

	function automatic logic signed [ACC_W-1:0] lMac(
		input logic signed [ACC_W-1:0] acc,
		input logic signed [SAMPLE_W-1:0] a,
		input logic signed [SAMPLE_W-1:0] b
	);
		logic signed [ACC_W:0] sum;
		sum = acc + lMult(a, b);
		if (sum[ACC_W] != sum[ACC_W-1])
			return sum[ACC_W] ? ACC_MIN : ACC_MAX;
		return sum[ACC_W-1:0];
	endfunction

	function automatic logic signed [ACC_W-1:0] lShlSat(
		input logic signed [ACC_W-1:0] x,
		input logic [SHIFT_W-1:0] n
	);
		logic signed [ACC_W-1:0] r;
		r = x;
		for (int k = 0; k < (1 << SHIFT_W); k++)
		begin
			if (k < n)
			begin
				if (r > (ACC_MAX >>> 1))
					r = ACC_MAX;
				else if (r < (ACC_MIN >>> 1))
					r = ACC_MIN;
				else
					r = r <<< 1;
			end
		end
		return r;
	endfunction

	function automatic logic signed [SAMPLE_W-1:0] shrArith(
		input logic signed [SAMPLE_W-1:0] x,
		input logic [SHIFT_W-1:0] n
	);
		return x >>> n;
	endfunction

	function automatic logic signed [SAMPLE_W-1:0] extractH(input accWord w);
		return w.half.hi;
	endfunction

endpackage
